// File: design/cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// data and address width
`define CPU_DATA_W 32

`define CPU_NREGS 16 // r0 is hardwired to zero

// address of the first instruction fetch
`define CPU_RESET_PC 32'h0000_0000

// encoding of HALTED
// stray state codes are steered here as well
`define CPU_HALT_STATE 3'd5

`endif

// File: design/isa_pkg.sv
`default_nettype none

package isa_pkg;

  // anything not listed decodes as illegal
  typedef enum logic [7:0] {
    OP_NOP  = 8'h00,
    OP_LDI  = 8'h01,
    OP_ADD  = 8'h10,
    OP_SUB  = 8'h11,
    OP_AND  = 8'h12,
    OP_OR   = 8'h13,
    OP_XOR  = 8'h14,
    OP_SHL  = 8'h15,
    OP_SHR  = 8'h16,
    OP_ADDI = 8'h17,
    OP_CMP  = 8'h18,
    OP_LD   = 8'h20,
    OP_ST   = 8'h21,
    OP_LDB  = 8'h22,
    OP_STB  = 8'h23,
    OP_BEQ  = 8'h30,
    OP_BNE  = 8'h31,
    OP_BLT  = 8'h32,
    OP_JMP  = 8'h33,
    OP_HALT = 8'hff
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SHL,
    ALU_SHR,
    ALU_PASSB
  } alu_func_e;

  typedef struct packed {
    opcode_e     opcode;
    logic [3:0]  ra;  // destination, store data
    logic [3:0]  rb;  // first source, base address
    logic [15:0] imm; // rc lives in imm[15:12]
  } instr_t;

endpackage

`default_nettype wire

// File: design/ctrl_pkg.sv
`default_nettype none

`include "cpu_defs.svh"

package ctrl_pkg;

  typedef enum logic [2:0] {
    FETCH     = 3'd0,
    DECODE    = 3'd1,
    EXEC      = 3'd2,
    MEM       = 3'd3,
    WRITEBACK = 3'd4,
    HALTED    = `CPU_HALT_STATE
  } state_e;

  typedef enum logic [1:0] {
    PC_HOLD,
    PC_NEXT, // pc + 4
    PC_REL,  // branch offset
    PC_REG   // jump to a
  } pcsel_e;

  typedef enum logic [1:0] {MAR_HOLD, MAR_ALU} marsel_e;

  typedef enum logic [1:0] {MDR_HOLD, MDR_BUS, MDR_B} mdrsel_e;

  typedef enum logic [1:0] {REG_ALU, REG_MDR} regsel_e;

  typedef enum logic [1:0] {ALU2_B, ALU2_IMM, ALU2_4} alu2sel_e;

  typedef struct packed {
    pcsel_e             pcsel;
    marsel_e            marsel;
    mdrsel_e            mdrsel;
    regsel_e            regsel;
    alu2sel_e           alu2sel;
    isa_pkg::alu_func_e alu_func;
    logic               ir_we;
    logic               a_we;
    logic               b_we;
    logic               ccr_we;
    logic               reg_we;
    logic               addr_mar; // drive mar instead of pc on the bus
    logic               byte_op;
    logic               src2_ra;  // read port 2 takes ra, else rc
  } ctrl_t;

endpackage

`default_nettype wire

// File: design/alu.sv
`default_nettype none

`include "cpu_defs.svh"

module alu (
  input  logic [`CPU_DATA_W-1:0] in1_i,
  input  logic [`CPU_DATA_W-1:0] in2_i,
  input  isa_pkg::alu_func_e     func_i,
  output logic [`CPU_DATA_W-1:0] out_o,
  output logic                   carry_o,
  output logic                   negative_o,
  output logic                   overflow_o,
  output logic                   zero_o
);
  import isa_pkg::*;

  logic                   sub;
  logic                   arith;
  logic [`CPU_DATA_W-1:0] addend;
  logic [`CPU_DATA_W:0]   sum;

  assign sub    = (func_i == ALU_SUB);
  assign arith  = sub || (func_i == ALU_ADD);
  assign addend = sub ? ~in2_i : in2_i; // two's complement subtract
  assign sum    = {1'b0, in1_i} + {1'b0, addend} + (`CPU_DATA_W+1)'(sub);

  always_comb begin
    case (func_i)
      ALU_AND:   out_o = in1_i & in2_i;
      ALU_OR:    out_o = in1_i | in2_i;
      ALU_XOR:   out_o = in1_i ^ in2_i;
      ALU_SHL:   out_o = in1_i << in2_i[4:0];
      ALU_SHR:   out_o = in1_i >> in2_i[4:0]; // logical
      ALU_PASSB: out_o = in2_i;
      default:   out_o = sum[`CPU_DATA_W-1:0];
    endcase
  end

  // carry set means no borrow on subtract
  assign carry_o    = arith & sum[`CPU_DATA_W];
  assign overflow_o = arith & (in1_i[`CPU_DATA_W-1] == addend[`CPU_DATA_W-1]) &
                      (sum[`CPU_DATA_W-1] != in1_i[`CPU_DATA_W-1]);
  assign negative_o = out_o[`CPU_DATA_W-1];
  assign zero_o     = (out_o == '0);

endmodule

`default_nettype wire

// File: design/register_file.sv
`default_nettype none

`include "cpu_defs.svh"

module register_file (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic [3:0]             rd1_addr_i,
  input  logic [3:0]             rd2_addr_i,
  input  logic [3:0]             wr_addr_i,
  input  logic [`CPU_DATA_W-1:0] wr_data_i,
  input  logic                   wr_en_i,
  output logic [`CPU_DATA_W-1:0] rd1_data_o,
  output logic [`CPU_DATA_W-1:0] rd2_data_o
);

  logic [`CPU_DATA_W-1:0] regs [`CPU_NREGS];

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      for (int i = 0; i < `CPU_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en_i && (wr_addr_i != 4'd0)) begin // r0 writes dropped
      regs[wr_addr_i] <= wr_data_i;
    end
  end

  assign rd1_data_o = (rd1_addr_i == 4'd0) ? '0 : regs[rd1_addr_i];
  assign rd2_data_o = (rd2_addr_i == 4'd0) ? '0 : regs[rd2_addr_i];

  wr_addr_known: assert property (@(posedge clk_i) disable iff (rst_i)
    wr_en_i |-> !$isunknown(wr_addr_i))
    else $error("register write with unknown address");

endmodule

`default_nettype wire

// File: design/bus_interface.sv
`default_nettype none

module bus_interface (
  input  logic        byte_op_i,
  input  logic [1:0]  addr_lo_i,
  input  logic [31:0] cpu_data_i,
  input  logic [31:0] bus_data_i,
  output logic [31:0] bus_data_o,
  output logic [31:0] cpu_data_o,
  output logic [3:0]  sel_o
);

  logic [7:0] lane_byte;

  // lane 0 holds the lowest address
  assign lane_byte = bus_data_i[{addr_lo_i, 3'b000} +: 8];

  always_comb begin
    if (byte_op_i) begin
      sel_o      = 4'b0001 << addr_lo_i;
      bus_data_o = {4{cpu_data_i[7:0]}}; // same byte on every lane
      cpu_data_o = {24'd0, lane_byte};
    end else begin
      sel_o      = 4'b1111;
      bus_data_o = cpu_data_i;
      cpu_data_o = bus_data_i;
    end
  end

  sel_nonzero: assert final (sel_o != 4'b0000)
    else $error("bus access with no byte lane selected");

endmodule

`default_nettype wire

// File: design/control.sv
`default_nettype none

module control (
  input  logic             clk_i,
  input  logic             rst_i,
  input  isa_pkg::instr_t  instr_i,
  input  logic [2:0]       ccr_i,
  input  logic             ack_i,
  output ctrl_pkg::ctrl_t  ctrl_o,
  output logic             cyc_o,
  output logic             we_o,
  output logic             halt_o,
  output logic             illegal_o
);
  import isa_pkg::*;
  import ctrl_pkg::*;

  state_e    state_q;
  state_e    state_d;
  logic      cyc_q;
  logic      we_q;
  logic      illegal_q;
  logic      bus_done;
  logic      known;
  logic      is_alu;
  logic      is_load;
  logic      is_store;
  logic      take;
  alu_func_e func;
  alu2sel_e  alu2;

  assign bus_done = cyc_q & ack_i; // ack without a cycle is ignored

  // opcode decode
  always_comb begin
    known    = 1'b1;
    is_alu   = 1'b0;
    is_load  = 1'b0;
    is_store = 1'b0;
    func     = ALU_ADD;
    alu2     = ALU2_B;
    case (instr_i.opcode)
      OP_LDI:  {is_alu, func, alu2} = {1'b1, ALU_PASSB, ALU2_IMM};
      OP_ADD:  is_alu = 1'b1;
      OP_SUB:  {is_alu, func} = {1'b1, ALU_SUB};
      OP_AND:  {is_alu, func} = {1'b1, ALU_AND};
      OP_OR:   {is_alu, func} = {1'b1, ALU_OR};
      OP_XOR:  {is_alu, func} = {1'b1, ALU_XOR};
      OP_SHL:  {is_alu, func} = {1'b1, ALU_SHL};
      OP_SHR:  {is_alu, func} = {1'b1, ALU_SHR};
      OP_ADDI: {is_alu, alu2} = {1'b1, ALU2_IMM};
      OP_CMP:  func = ALU_SUB;
      OP_LD, OP_LDB: {is_load, alu2} = {1'b1, ALU2_IMM};  // address = a + imm
      OP_ST, OP_STB: {is_store, alu2} = {1'b1, ALU2_IMM};
      OP_NOP, OP_BEQ, OP_BNE, OP_BLT, OP_JMP, OP_HALT: ;
      default: known = 1'b0;
    endcase
  end

  // ccr is {carry, less, zero}
  always_comb begin
    case (instr_i.opcode)
      OP_BEQ:  take = ccr_i[0];
      OP_BNE:  take = !ccr_i[0];
      OP_BLT:  take = ccr_i[1];
      default: take = 1'b0;
    endcase
  end

  always_comb begin
    ctrl_o          = '0;
    ctrl_o.alu_func = func;
    ctrl_o.alu2sel  = alu2;
    ctrl_o.regsel   = is_load ? REG_MDR : REG_ALU;
    ctrl_o.addr_mar = (state_q == MEM);
    ctrl_o.byte_op  = (state_q == MEM) &&
                      ((instr_i.opcode == OP_LDB) || (instr_i.opcode == OP_STB));
    ctrl_o.src2_ra  = is_store;
    state_d         = state_q;
    case (state_q)
      FETCH: begin
        if (bus_done) begin
          ctrl_o.ir_we = 1'b1;
          ctrl_o.pcsel = PC_NEXT;
          state_d      = DECODE;
        end
      end
      DECODE: begin
        ctrl_o.a_we = 1'b1;
        ctrl_o.b_we = 1'b1;
        state_d     = EXEC;
      end
      EXEC: begin
        if (!known || instr_i.opcode == OP_HALT) begin
          state_d = HALTED;
        end else if (is_alu) begin
          state_d = WRITEBACK;
        end else if (is_load || is_store) begin
          ctrl_o.marsel = MAR_ALU;
          ctrl_o.mdrsel = is_store ? MDR_B : MDR_HOLD;
          state_d       = MEM;
        end else begin
          ctrl_o.ccr_we = (instr_i.opcode == OP_CMP);
          if (take) ctrl_o.pcsel = PC_REL;
          if (instr_i.opcode == OP_JMP) ctrl_o.pcsel = PC_REG;
          state_d = FETCH;
        end
      end
      MEM: begin
        if (bus_done) begin
          ctrl_o.mdrsel = is_load ? MDR_BUS : MDR_HOLD;
          state_d       = is_load ? WRITEBACK : FETCH;
        end
      end
      WRITEBACK: begin
        ctrl_o.reg_we = 1'b1;
        state_d       = FETCH;
      end
      default: state_d = HALTED; // HALTED and stray codes
    endcase
  end

  // strobes come from flops so they stay clean and low in reset
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q   <= FETCH;
      cyc_q     <= 1'b0;
      we_q      <= 1'b0;
      illegal_q <= 1'b0;
    end else begin
      state_q <= state_d;
      cyc_q   <= (state_d == FETCH) || (state_d == MEM);
      we_q    <= (state_d == MEM) && is_store;
      if (state_q == EXEC && !known) illegal_q <= 1'b1;
    end
  end

  assign cyc_o     = cyc_q;
  assign we_o      = we_q;
  assign halt_o    = (state_q == HALTED);
  assign illegal_o = illegal_q;

  halted_quiet: assert property (@(posedge clk_i) disable iff (rst_i)
    state_q == HALTED |-> !cyc_o)
    else $error("bus cycle while halted");

  we_in_cycle: assert property (@(posedge clk_i) disable iff (rst_i)
    we_o |-> cyc_o)
    else $error("we_o outside a bus cycle");

endmodule

`default_nettype wire

// File: design/cpu_core.sv
`default_nettype none

`include "cpu_defs.svh"

module cpu_core (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   ack_i,
  input  logic [`CPU_DATA_W-1:0] dat_i,
  output logic [`CPU_DATA_W-1:0] adr_o,
  output logic [`CPU_DATA_W-1:0] dat_o,
  output logic [3:0]             sel_o,
  output logic                   cyc_o,
  output logic                   we_o,
  output logic                   halt_o,
  output logic                   illegal_o
);
  import isa_pkg::*;
  import ctrl_pkg::*;

  ctrl_t                  ctrl;
  instr_t                 ir;
  logic [`CPU_DATA_W-1:0] pc;
  logic [`CPU_DATA_W-1:0] mar;
  logic [`CPU_DATA_W-1:0] mdr;
  logic [`CPU_DATA_W-1:0] a;
  logic [`CPU_DATA_W-1:0] b;
  logic [2:0]             ccr;
  logic [`CPU_DATA_W-1:0] pc_d;
  logic [`CPU_DATA_W-1:0] mdr_d;
  logic [`CPU_DATA_W-1:0] imm_sext;
  logic [`CPU_DATA_W-1:0] alu_in2;
  logic [`CPU_DATA_W-1:0] alu_out;
  logic [`CPU_DATA_W-1:0] reg_wdata;
  logic [`CPU_DATA_W-1:0] rd1_data;
  logic [`CPU_DATA_W-1:0] rd2_data;
  logic [`CPU_DATA_W-1:0] load_data;
  logic [3:0]             rd2_addr;
  logic                   alu_carry;
  logic                   alu_negative;
  logic                   alu_overflow;
  logic                   alu_zero;

  assign imm_sext = {{16{ir.imm[15]}}, ir.imm};
  assign adr_o    = ctrl.addr_mar ? mar : pc;
  assign rd2_addr = ctrl.src2_ra ? ir.ra : ir.imm[15:12]; // ra or rc

  always_comb begin
    case (ctrl.pcsel)
      PC_NEXT: pc_d = pc + 32'd4;
      PC_REL:  pc_d = pc + {imm_sext[29:0], 2'b00}; // pc already past the branch
      PC_REG:  pc_d = a;
      default: pc_d = pc;
    endcase
    case (ctrl.mdrsel)
      MDR_BUS: mdr_d = load_data;
      MDR_B:   mdr_d = b;
      default: mdr_d = mdr;
    endcase
    case (ctrl.alu2sel)
      ALU2_IMM: alu_in2 = imm_sext;
      ALU2_4:   alu_in2 = 32'd4;
      default:  alu_in2 = b;
    endcase
    reg_wdata = (ctrl.regsel == REG_MDR) ? mdr : alu_out;
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      pc  <= `CPU_RESET_PC;
      ir  <= '0; // decodes as NOP
      mar <= '0;
      mdr <= '0;
      a   <= '0;
      b   <= '0;
      ccr <= '0;
    end else begin
      pc  <= pc_d;
      mdr <= mdr_d;
      if (ctrl.marsel == MAR_ALU) mar <= alu_out;
      if (ctrl.ir_we) ir <= instr_t'(dat_i);
      if (ctrl.a_we) a <= rd1_data;
      if (ctrl.b_we) b <= rd2_data;
      if (ctrl.ccr_we) ccr <= {alu_carry, alu_negative ^ alu_overflow, alu_zero};
    end
  end

  control i_control (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .instr_i   (ir),
    .ccr_i     (ccr),
    .ack_i     (ack_i),
    .ctrl_o    (ctrl),
    .cyc_o     (cyc_o),
    .we_o      (we_o),
    .halt_o    (halt_o),
    .illegal_o (illegal_o)
  );

  alu i_alu (
    .in1_i      (a),
    .in2_i      (alu_in2),
    .func_i     (ctrl.alu_func),
    .out_o      (alu_out),
    .carry_o    (alu_carry),
    .negative_o (alu_negative),
    .overflow_o (alu_overflow),
    .zero_o     (alu_zero)
  );

  register_file i_register_file (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .rd1_addr_i (ir.rb),
    .rd2_addr_i (rd2_addr),
    .wr_addr_i  (ir.ra),
    .wr_data_i  (reg_wdata),
    .wr_en_i    (ctrl.reg_we),
    .rd1_data_o (rd1_data),
    .rd2_data_o (rd2_data)
  );

  bus_interface i_bus_interface (
    .byte_op_i  (ctrl.byte_op),
    .addr_lo_i  (adr_o[1:0]),
    .cpu_data_i (mdr),
    .bus_data_i (dat_i),
    .bus_data_o (dat_o),
    .cpu_data_o (load_data),
    .sel_o      (sel_o)
  );

  adr_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    cyc_o && !ack_i |=> $stable(adr_o))
    else $error("adr_o moved while waiting for ack_i");

endmodule

`default_nettype wire

// File: testbench/tb_memory.sv
`default_nettype none

module tb_memory (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        cyc_i,
  input  logic        we_i,
  input  logic [31:0] adr_i,
  input  logic [31:0] dat_i,
  input  logic [3:0]  sel_i,
  output logic [31:0] dat_o,
  output logic        ack_o
);
  import isa_pkg::*;

  localparam int MEM_WORDS = 128;

  logic [31:0] mem [MEM_WORDS];
  logic [31:0] lcg_state;
  logic [1:0]  wait_cnt;
  logic        busy;
  logic [6:0]  word;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] enc(input opcode_e op, input int ra, input int rb,
                                      input logic [15:0] imm);
    return {op, 4'(ra), 4'(rb), imm};
  endfunction

  task automatic patch_word(input int idx, input logic [31:0] value);
    mem[idx] = value;
  endtask

  task automatic load_program();
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = (i * 32'h9e37_79b9) ^ 32'h5a5a_0000; // fill tied to the address
    end
    mem[0]  = enc(OP_LDI, 1, 0, 16'h1234);
    mem[1]  = enc(OP_LDI, 2, 0, 16'hfffd);
    mem[2]  = enc(OP_ADD, 3, 1, 16'h2000); // rc in imm[15:12]
    mem[3]  = enc(OP_ST, 3, 0, 16'h0100);
    mem[4]  = enc(OP_SUB, 4, 1, 16'h2000);
    mem[5]  = enc(OP_ST, 4, 0, 16'h0104);
    mem[6]  = enc(OP_XOR, 5, 1, 16'h2000);
    mem[7]  = enc(OP_ST, 5, 0, 16'h0108);
    mem[8]  = enc(OP_LDI, 6, 0, 16'h0004);
    mem[9]  = enc(OP_SHL, 7, 1, 16'h6000);
    mem[10] = enc(OP_ST, 7, 0, 16'h010c);
    mem[11] = enc(OP_SHR, 8, 2, 16'h6000);
    mem[12] = enc(OP_ST, 8, 0, 16'h0110);
    mem[13] = enc(OP_ADDI, 9, 1, 16'h0010);
    mem[14] = enc(OP_ST, 9, 0, 16'h0114);
    mem[15] = enc(OP_STB, 1, 0, 16'h0119);
    mem[16] = enc(OP_LDB, 11, 0, 16'h0119);
    mem[17] = enc(OP_ST, 11, 0, 16'h011c);
    mem[18] = enc(OP_CMP, 0, 1, 16'h2000);  // r1 vs r2, greater
    mem[19] = enc(OP_BEQ, 0, 0, 16'h0001);
    mem[20] = enc(OP_BLT, 0, 0, 16'h0001);
    mem[21] = enc(OP_BNE, 0, 0, 16'h0001);
    mem[22] = enc(OP_ST, 1, 0, 16'h0180);  // poison
    mem[23] = enc(OP_CMP, 0, 2, 16'h1000);  // r2 vs r1, less
    mem[24] = enc(OP_BLT, 0, 0, 16'h0001);
    mem[25] = enc(OP_ST, 1, 0, 16'h0184);
    mem[26] = enc(OP_CMP, 0, 1, 16'h1000);  // equal
    mem[27] = enc(OP_BNE, 0, 0, 16'h0001);
    mem[28] = enc(OP_BEQ, 0, 0, 16'h0001);
    mem[29] = enc(OP_ST, 1, 0, 16'h0188);
    mem[30] = enc(OP_LDI, 12, 0, 16'h0084);
    mem[31] = enc(OP_JMP, 0, 12, 16'h0000);
    mem[32] = enc(OP_ST, 1, 0, 16'h018c);
    mem[33] = enc(OP_ST, 12, 0, 16'h0120);
    mem[34] = enc(OP_HALT, 0, 0, 16'h0000);
  endtask

  initial begin
    lcg_state = 32'hd27bad2b;
    ack_o     = 1'b0;
    dat_o     = '0;
    busy      = 1'b0;
    wait_cnt  = '0;
    load_program();
  end

  always @(posedge clk_i) begin
    #1;
    ack_o = 1'b0; // one-cycle ack
    if (rst_i) begin
      busy = 1'b0;
    end else if (cyc_i) begin
      if (!busy) begin
        lcg_state = lcg_next(lcg_state);
        wait_cnt  = lcg_state[31:30];
        busy      = 1'b1;
      end
      if (wait_cnt == 0) begin
        word  = adr_i[8:2];
        ack_o = 1'b1;
        busy  = 1'b0;
        dat_o = mem[word];
        if (we_i) begin
          for (int k = 0; k < 4; k++) begin
            if (sel_i[k]) mem[word][8*k +: 8] = dat_i[8*k +: 8];
          end
        end
      end else begin
        wait_cnt = wait_cnt - 2'd1;
      end
    end
  end

endmodule

`default_nettype wire

// File: testbench/tb_cpu.sv
`default_nettype none

`include "cpu_defs.svh"

module tb_cpu;

  localparam int PROG_WORDS = 35;
  localparam int N_WRITES   = 9;
  localparam int WATCHDOG   = 2 * PROG_WORDS * 6 * 4 * 20;

  logic        clk_i = 1'b0;
  logic        rst_i = 1'b0;
  logic        ack_i;
  logic [31:0] dat_i;
  logic [31:0] adr_o;
  logic [31:0] dat_o;
  logic [3:0]  sel_o;
  logic        cyc_o;
  logic        we_o;
  logic        halt_o;
  logic        illegal_o;

  logic [31:0] exp_adr [N_WRITES];
  logic [31:0] exp_dat [N_WRITES];
  logic [3:0]  exp_sel [N_WRITES];
  int          wr_idx = 0;
  logic [31:0] r1_val = 32'h0000_1234;
  logic [31:0] r2_val = 32'hffff_fffd; // sign-extended imm

  always #10 clk_i = ~clk_i;

  cpu_core i_cpu_core (.*);

  tb_memory i_memory (
    .clk_i (clk_i), .rst_i (rst_i), .cyc_i (cyc_o), .we_i (we_o), .adr_i (adr_o),
    .dat_i (dat_o), .sel_i (sel_o), .dat_o (dat_i), .ack_o (ack_i)
  );

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] expv, input logic [31:0] act);
    value_match: assert (act === expv)
    else begin
      $display("Error at %0t: %s expected %h got %h", $time, name, expv, act);
      fail_run("value mismatch");
    end
  endtask

  reset_quiet: assert property (@(posedge clk_i)
    rst_i |-> !cyc_o && !we_o && !halt_o && !illegal_o)
    else fail_run("bus strobe or status active during reset");
  bus_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    cyc_o && !ack_i |=> $stable(adr_o) && $stable(we_o) && $stable(dat_o) && $stable(sel_o))
    else fail_run("bus signals moved while waiting for ack");
  halt_quiet: assert property (@(posedge clk_i) disable iff (rst_i) halt_o |-> !cyc_o)
    else fail_run("bus cycle after halt");
  illegal_halt: assert property (@(posedge clk_i) disable iff (rst_i)
    $rose(illegal_o) |-> $rose(halt_o))
    else fail_run("illegal_o rose without halt_o");
  // program area is only ever fetched, always as a word
  fetch_word: assert property (@(posedge clk_i) disable iff (rst_i)
    cyc_o && !we_o && adr_o < 32'h100 |-> sel_o == 4'b1111)
    else fail_run("instruction fetch without all byte lanes");

  // every acknowledged store is compared against the table in order
  always @(posedge clk_i) begin
    if (!rst_i && cyc_o && ack_i && we_o) begin
      if (adr_o >= 32'h180) fail_run("store reached the poison area");
      if (wr_idx >= N_WRITES) fail_run("more stores than expected");
      check_value("adr_o", exp_adr[wr_idx], adr_o);
      check_value("dat_o", exp_dat[wr_idx], dat_o);
      check_value("sel_o", {28'd0, exp_sel[wr_idx]}, {28'd0, sel_o});
      wr_idx++;
    end
  end

  task automatic run_program(input logic expect_illegal);
    wr_idx = 0;
    repeat (3) @(posedge clk_i);
    #2 rst_i = 1'b0;
    @(posedge clk_i);
    #2;
    check_value("cyc_o", 32'd1, {31'd0, cyc_o});
    check_value("adr_o", `CPU_RESET_PC, adr_o);
    check_value("we_o", 32'd0, {31'd0, we_o});
    while (halt_o !== 1'b1) @(posedge clk_i);
    check_value("illegal_o", {31'd0, expect_illegal}, {31'd0, illegal_o});
    check_value("store count", N_WRITES, wr_idx);
    repeat (5) @(posedge clk_i);
    check_value("halt_o", 32'd1, {31'd0, halt_o});
  endtask

  initial begin
    exp_adr[0] = 32'h100;
    exp_dat[0] = r1_val + r2_val;
    exp_adr[1] = 32'h104;
    exp_dat[1] = r1_val - r2_val;
    exp_adr[2] = 32'h108;
    exp_dat[2] = r1_val ^ r2_val;
    exp_adr[3] = 32'h10c;
    exp_dat[3] = r1_val << 4;
    exp_adr[4] = 32'h110;
    exp_dat[4] = r2_val >> 4;
    exp_adr[5] = 32'h114;
    exp_dat[5] = r1_val + 32'h10;
    exp_adr[6] = 32'h119;
    exp_dat[6] = {4{r1_val[7:0]}}; // byte on every lane
    exp_adr[7] = 32'h11c;
    exp_dat[7] = {24'd0, r1_val[7:0]};
    exp_adr[8] = 32'h120;
    exp_dat[8] = 32'd33 * 4;      // jump target
    for (int i = 0; i < N_WRITES; i++) exp_sel[i] = 4'b1111;
    exp_sel[6] = 4'b0010;
    #2 rst_i = 1'b1;
    run_program(1'b0);
    @(posedge clk_i);
    #2 rst_i = 1'b1;
    i_memory.patch_word(34, 32'h7700_0000); // HALT becomes illegal
    run_program(1'b1);
    $display("All checks passed");
    $finish;
  end

  initial begin
    #(WATCHDOG);
    $display("watchdog expired before the program halted");
    $display("Checks failed");
    $fatal(1);
  end

endmodule

`default_nettype wire

// File: tb.f
+incdir+design
design/isa_pkg.sv
design/ctrl_pkg.sv
design/alu.sv
design/register_file.sv
design/bus_interface.sv
design/control.sv
design/cpu_core.sv
testbench/tb_memory.sv
testbench/tb_cpu.sv
